// ==== hw/alu_contr_defs.svh ====
////////////////////////////////////////
// Field widths and the reset microword of the
// ALU controller. Included by the package and RTL.
////////////////////////////////////////
`ifndef ALU_CONTR_DEFS_SVH
`define ALU_CONTR_DEFS_SVH

`default_nettype none

// microword field widths.
`define ALU_FIELD_W 3  // source, function and destination.
`define ALU_SEL_W   2  // link, carry-in, status and Q select.

// microword decoded while rst is high.
`define ALU_RST_SRC  3'd0  // AQ.
`define ALU_RST_FUNC 3'd0  // ADD.
`define ALU_RST_DEST 3'd1  // NOP, nothing written.
`define ALU_RST_LINK 2'd0  // zero fill.
`define ALU_RST_CIN  2'd0  // carry in held low.
`define ALU_RST_STS  2'd0

`default_nettype wire

`endif

// ==== hw/alu_contr_pkg.sv ====
////////////////////////////////////////
// Microword field encodings shared by the
// ALU controller RTL and its testbench.
////////////////////////////////////////
`include "alu_contr_defs.svh"
`default_nettype none

package alu_contr_pkg;

  // operand pair routed to the R and S ports.
  typedef enum logic [`ALU_FIELD_W-1:0] {
    SRC_AQ = 3'd0,
    SRC_AB = 3'd1,
    SRC_ZQ = 3'd2,
    SRC_ZB = 3'd3,
    SRC_ZA = 3'd4,
    SRC_DA = 3'd5,
    SRC_DQ = 3'd6,
    SRC_DZ = 3'd7
  } alu_src_e;

  // codes 3 and up are the logic functions.
  typedef enum logic [`ALU_FIELD_W-1:0] {
    FN_ADD   = 3'd0,
    FN_SUBR  = 3'd1,
    FN_SUBS  = 3'd2,
    FN_OR    = 3'd3,
    FN_AND   = 3'd4,
    FN_NOTRS = 3'd5,
    FN_EXOR  = 3'd6,
    FN_EXNOR = 3'd7
  } alu_func_e;

  typedef enum logic [`ALU_FIELD_W-1:0] {
    DST_QREG  = 3'd0,
    DST_NOP   = 3'd1,
    DST_RAMA  = 3'd2,
    DST_RAMF  = 3'd3,
    DST_RAMQD = 3'd4,  // RAM and Q shift down.
    DST_RAMD  = 3'd5,
    DST_RAMQU = 3'd6,  // RAM and Q shift up.
    DST_RAMU  = 3'd7
  } alu_dest_e;

  // fill for the end entering a shift.
  typedef enum logic [`ALU_SEL_W-1:0] {
    LINK_ZERO  = 2'd0,
    LINK_ROT   = 2'd1,
    LINK_CARRY = 2'd2,
    LINK_ARITH = 2'd3
  } link_sel_e;

  typedef enum logic [`ALU_SEL_W-1:0] {
    CIN_C0   = 2'd0,
    CIN_C1   = 2'd1,
    CIN_STS6 = 2'd2,
    CIN_GPR0 = 2'd3
  } cin_sel_e;

  typedef enum logic [`ALU_SEL_W-1:0] {
    QSEL_HOLD  = 2'd0,
    QSEL_LOAD  = 2'd1,
    QSEL_RIGHT = 2'd2,
    QSEL_LEFT  = 2'd3
  } qsel_e;

endpackage

`default_nettype wire

// ==== hw/alu_shift_if.sv ====
////////////////////////////////////////
// Registered shift and carry controls passed
// from the field decoder to the link logic.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

interface alu_shift_if (
  input logic aluclk,
  input logic rst
);
  import alu_contr_pkg::*;

  logic      shift_up;  // destination 6 or 7.
  logic      shift_dn;  // destination 4 or 5.
  logic      dbl;       // Q shifts along with RAM.
  link_sel_e link_sel;
  cin_sel_e  cin_sel;

  modport src (
    output shift_up,
    output shift_dn,
    output dbl,
    output link_sel,
    output cin_sel
  );

  // clock and reset only serve the checks on the link side.
  modport dst (
    input aluclk,
    input rst,
    input shift_up,
    input shift_dn,
    input dbl,
    input link_sel,
    input cin_sel
  );

endinterface

`default_nettype wire

// ==== hw/alu_field_decode.sv ====
////////////////////////////////////////
// Microword field decoder. Samples the fields on
// every aluclk edge and holds the decoded controls.
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_contr_defs.svh"
`default_nettype none

module alu_field_decode (
  input  logic                     aluclk,
  input  logic                     rst,
  input  alu_contr_pkg::alu_src_e  src,
  input  alu_contr_pkg::alu_func_e func,
  input  alu_contr_pkg::alu_dest_e dest,
  input  alu_contr_pkg::link_sel_e link_sel,
  input  alu_contr_pkg::cin_sel_e  cin_sel,
  input  logic [`ALU_SEL_W-1:0]    sts_ctl,
  output logic                     ra,
  output logic                     rd,
  output logic                     sa,
  output logic                     sb,
  output logic                     rsn,
  output logic                     fsel,
  output logic                     log,
  output logic                     alui4,
  output logic                     alui7,
  output logic                     alui8n,
  output logic                     alud2n,
  output logic                     bdest,
  output alu_contr_pkg::qsel_e     qsel,
  output logic [`ALU_SEL_W-1:0]    csts,
  alu_shift_if.src                 shift
);
  import alu_contr_pkg::*;

  // microword as seen by the decoders.
  alu_src_e              src_w;
  alu_func_e             func_w;
  alu_dest_e             dest_w;
  link_sel_e             link_w;
  cin_sel_e              cin_w;
  logic [`ALU_SEL_W-1:0] sts_w;

  logic [3:0] oper_d;  // {ra, rd, sa, sb}.
  logic [3:0] fn_d;    // {rsn, fsel, log, alui4}.
  logic [3:0] dst_d;   // {alui7, alui8n, alud2n, bdest}.
  logic [2:0] shift_d; // {up, down, double}.
  qsel_e      qsel_d;

  // reset loads the NOP microword through the normal decode path.
  always_comb begin
    if (rst) begin
      src_w  = alu_src_e'(`ALU_RST_SRC);
      func_w = alu_func_e'(`ALU_RST_FUNC);
      dest_w = alu_dest_e'(`ALU_RST_DEST);
      link_w = link_sel_e'(`ALU_RST_LINK);
      cin_w  = cin_sel_e'(`ALU_RST_CIN);
      sts_w  = `ALU_RST_STS;
    end else begin
      src_w  = src;
      func_w = func;
      dest_w = dest;
      link_w = link_sel;
      cin_w  = cin_sel;
      sts_w  = sts_ctl;
    end
  end

  always_comb begin
    oper_d[3] = src_w inside {SRC_AQ, SRC_AB};          // A on R.
    oper_d[2] = src_w inside {SRC_DA, SRC_DQ, SRC_DZ};  // D on R.
    oper_d[1] = src_w inside {SRC_ZA, SRC_DA};          // A on S.
    oper_d[0] = src_w inside {SRC_AB, SRC_ZB};          // B on S.

    fn_d[3] = (func_w == FN_SUBR);
    fn_d[2] = (func_w == FN_SUBS);
    fn_d[1] = func_w inside {FN_OR, FN_AND, FN_NOTRS, FN_EXOR, FN_EXNOR};
    fn_d[0] = func_w[1];

    dst_d[3] = dest_w[1];
    dst_d[2] = ~dest_w[2];
    dst_d[1] = (dest_w != DST_RAMA);  // low only when A goes to Y.
    dst_d[0] = (dest_w != DST_QREG) && (dest_w != DST_NOP);  // RAM written.

    shift_d[2] = dest_w inside {DST_RAMQU, DST_RAMU};
    shift_d[1] = dest_w inside {DST_RAMQD, DST_RAMD};
    shift_d[0] = dest_w inside {DST_RAMQD, DST_RAMQU};
  end

  always_comb begin
    case (dest_w)
      DST_QREG:  qsel_d = QSEL_LOAD;
      DST_RAMQD: qsel_d = QSEL_RIGHT;
      DST_RAMQU: qsel_d = QSEL_LEFT;
      default:   qsel_d = QSEL_HOLD;
    endcase
  end

  always_ff @(posedge aluclk) begin
    {ra, rd, sa, sb}                   <= oper_d;
    {rsn, fsel, log, alui4}            <= fn_d;
    {alui7, alui8n, alud2n, bdest}     <= dst_d;
    {shift.shift_up, shift.shift_dn, shift.dbl} <= shift_d;
    qsel                               <= qsel_d;
    shift.link_sel                     <= link_w;
    shift.cin_sel                      <= cin_w;
    csts                               <= sts_w;
  end

  // the link logic relies on at most one shift direction.
  a_shift_dir: assert property (@(posedge aluclk) disable iff (rst)
    !(shift.shift_up && shift.shift_dn));

endmodule

`default_nettype wire

// ==== hw/alu_link_ctl.sv ====
////////////////////////////////////////
// Shift link fill and carry-in select, combinational
// from the held controls and live datapath bits.
////////////////////////////////////////
`timescale 1ns/1ps
`default_nettype none

module alu_link_ctl (
  alu_shift_if.dst shift,
  input  logic     f0,
  input  logic     f15,
  input  logic     q0,
  input  logic     q15,
  input  logic     cry,
  input  logic     sts6,
  input  logic     gpr0,
  output logic     rli,
  output logic     rri,
  output logic     qli,
  output logic     mi,
  output logic     ci
);
  import alu_contr_pkg::*;

  // bit entering RAM bit 15 on a down shift.
  always_comb begin
    rri = 1'b0;
    if (shift.shift_dn) begin
      case (shift.link_sel)
        LINK_ROT:   rri = shift.dbl ? q0 : f0;  // wrap the low end.
        LINK_CARRY: rri = cry;
        LINK_ARITH: rri = f15;                  // sign fill.
        default:    rri = 1'b0;
      endcase
    end
  end

  // bit entering RAM bit 0 on an up shift.
  always_comb begin
    rli = 1'b0;
    if (shift.shift_up) begin
      if (shift.dbl) begin
        rli = q15;  // Q carries into RAM.
      end else begin
        case (shift.link_sel)
          LINK_ROT:   rli = f15;
          LINK_CARRY: rli = cry;
          default:    rli = 1'b0;
        endcase
      end
    end
  end

  // Q picks up the RAM msb only on a double rotate up.
  assign qli = shift.shift_up & shift.dbl & (shift.link_sel == LINK_ROT) & f15;

  assign mi = shift.shift_dn ? f0 : (shift.shift_up ? f15 : 1'b0);

  always_comb begin
    case (shift.cin_sel)
      CIN_C1:   ci = 1'b1;
      CIN_STS6: ci = sts6;
      CIN_GPR0: ci = gpr0;
      default:  ci = 1'b0;
    endcase
  end

  // the held select from the decoder must settle ci once reset is done.
  a_ci_known: assert property (@(posedge shift.aluclk) disable iff (shift.rst)
    !$isunknown(ci));

endmodule

`default_nettype wire

// ==== hw/alu_contr.sv ====
////////////////////////////////////////
// ALU controller top level. Takes one microword
// per aluclk and drives the Am2901 control lines.
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_contr_defs.svh"
`default_nettype none

module alu_contr (
  input  logic                    aluclk,
  input  logic                    rst,
  input  logic [`ALU_FIELD_W-1:0] csalui_src,
  input  logic [`ALU_FIELD_W-1:0] csalui_func,
  input  logic [`ALU_FIELD_W-1:0] csalui_dest,
  input  logic [`ALU_SEL_W-1:0]   csmis,     // link select.
  input  logic [`ALU_SEL_W-1:0]   cscinsel,
  input  logic [`ALU_SEL_W-1:0]   csst,
  input  logic                    f0,
  input  logic                    f15,
  input  logic                    q0,
  input  logic                    q15,
  input  logic                    cry,
  input  logic                    sts6,
  input  logic                    gpr0,
  output logic                    ra,
  output logic                    rd,
  output logic                    sa,
  output logic                    sb,
  output logic                    rsn,
  output logic                    fsel,
  output logic                    log,
  output logic                    alui4,
  output logic                    alui7,
  output logic                    alui8n,
  output logic                    alud2n,
  output logic                    bdest,
  output logic [`ALU_SEL_W-1:0]   qsel,
  output logic                    rli,
  output logic                    rri,
  output logic                    qli,
  output logic                    mi,
  output logic                    ci,
  output logic [`ALU_SEL_W-1:0]   csts
);
  import alu_contr_pkg::*;

  alu_shift_if u_shift_if (
    .aluclk (aluclk),
    .rst    (rst)
  );

  alu_field_decode u_field_decode (
    .aluclk   (aluclk),
    .rst      (rst),
    .src      (alu_src_e'(csalui_src)),
    .func     (alu_func_e'(csalui_func)),
    .dest     (alu_dest_e'(csalui_dest)),
    .link_sel (link_sel_e'(csmis)),
    .cin_sel  (cin_sel_e'(cscinsel)),
    .sts_ctl  (csst),
    .ra       (ra),
    .rd       (rd),
    .sa       (sa),
    .sb       (sb),
    .rsn      (rsn),
    .fsel     (fsel),
    .log      (log),
    .alui4    (alui4),
    .alui7    (alui7),
    .alui8n   (alui8n),
    .alud2n   (alud2n),
    .bdest    (bdest),
    .qsel     (qsel),
    .csts     (csts),
    .shift    (u_shift_if.src)
  );

  alu_link_ctl u_link_ctl (
    .shift (u_shift_if.dst),
    .f0    (f0),
    .f15   (f15),
    .q0    (q0),
    .q15   (q15),
    .cry   (cry),
    .sts6  (sts6),
    .gpr0  (gpr0),
    .rli   (rli),
    .rri   (rri),
    .qli   (qli),
    .mi    (mi),
    .ci    (ci)
  );

endmodule

`default_nettype wire

// ==== testbench/tb_alu_contr.sv ====
////////////////////////////////////////
// Directed testbench for the ALU controller.
// Run it through filelist.f with tb_alu_contr on top.
////////////////////////////////////////
`timescale 1ns/1ps
`include "alu_contr_defs.svh"
`default_nettype none

module tb_alu_contr;
  import alu_contr_pkg::*;

  localparam int directed_words = 56;
  localparam int stream_words   = 64;
  localparam int run_cycles     = 4 + directed_words * 3 + stream_words + 1;
  localparam int watchdog_ns    = run_cycles * 20 + 200;

  logic                    aluclk;
  logic                    rst;
  logic [`ALU_FIELD_W-1:0] csalui_src, csalui_func, csalui_dest;
  logic [`ALU_SEL_W-1:0]   csmis, cscinsel, csst;
  logic                    f0, f15, q0, q15, cry, sts6, gpr0;
  logic                    ra, rd, sa, sb, rsn, fsel, log, alui4;
  logic                    alui7, alui8n, alud2n, bdest;
  logic [`ALU_SEL_W-1:0]   qsel, csts;
  logic                    rli, rri, qli, mi, ci;

  logic [15:0] dec_got;
  logic [4:0]  link_got;
  logic [31:0] lfsr_state = 32'hb5831ef6;
  int          check_count = 0;
  int          error_count = 0;
  int          test_count  = 0;

  // word layout is {src, func, dest, link, cin, sts}, dp is {f0, f15, q0, q15, cry, sts6, gpr0}.
  assign dec_got  = {ra, rd, sa, sb, rsn, fsel, log, alui4, alui7, alui8n, alud2n, bdest,
                     qsel, csts};
  assign link_got = {rli, rri, qli, mi, ci};

  alu_contr u_alu_contr (.*);

  initial begin
    aluclk = 1'b0;
    forever #10 aluclk = ~aluclk;
  end

  initial begin
    #(watchdog_ns);
    $display("watchdog expired before the tests finished");
    $display("Simulation failed");
    $finish;
  end

  // galois lfsr, one step per bit handed out.
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] val;
    val = '0;
    for (int i = 0; i < n; i++) begin
      lfsr_state = lfsr_state[0] ? ((lfsr_state >> 1) ^ 32'h80200003) : (lfsr_state >> 1);
      val = {val[30:0], lfsr_state[0]};
    end
    return val;
  endfunction

  function automatic logic [15:0] decode_model(input logic [14:0] w);
    logic [2:0] s, f, d;
    logic [1:0] q_e;
    s = w[14:12];
    f = w[11:9];
    d = w[8:6];
    case (d)
      DST_QREG:  q_e = QSEL_LOAD;
      DST_RAMQD: q_e = QSEL_RIGHT;
      DST_RAMQU: q_e = QSEL_LEFT;
      default:   q_e = QSEL_HOLD;
    endcase
    return {s == SRC_AQ || s == SRC_AB,
            s == SRC_DA || s == SRC_DQ || s == SRC_DZ,
            s == SRC_ZA || s == SRC_DA,
            s == SRC_AB || s == SRC_ZB,
            f == FN_SUBR, f == FN_SUBS, f >= 3'd3, f[1],
            d[1], ~d[2], d != DST_RAMA, d >= 3'd2,
            q_e, w[1:0]};
  endfunction

  function automatic logic [4:0] link_model(input logic [14:0] w, input logic [6:0] dp);
    logic       b_f0, b_f15, b_q0, b_q15, b_cry, b_sts6, b_gpr0;
    logic       up, dn, dbl, rli_e, rri_e, ci_e;
    logic [1:0] l;
    {b_f0, b_f15, b_q0, b_q15, b_cry, b_sts6, b_gpr0} = dp;
    l   = w[5:4];
    dn  = (w[8:6] == 3'd4) || (w[8:6] == 3'd5);
    up  = (w[8:6] == 3'd6) || (w[8:6] == 3'd7);
    dbl = (w[8:6] == 3'd4) || (w[8:6] == 3'd6);
    rri_e = 1'b0;
    if (dn && l == LINK_ROT) rri_e = dbl ? b_q0 : b_f0;
    if (dn && l == LINK_CARRY) rri_e = b_cry;
    if (dn && l == LINK_ARITH) rri_e = b_f15;  // sign fill.
    rli_e = 1'b0;
    if (up && dbl) rli_e = b_q15;
    else if (up && l == LINK_ROT) rli_e = b_f15;
    else if (up && l == LINK_CARRY) rli_e = b_cry;
    case (w[3:2])
      CIN_C1:   ci_e = 1'b1;
      CIN_STS6: ci_e = b_sts6;
      CIN_GPR0: ci_e = b_gpr0;
      default:  ci_e = 1'b0;
    endcase
    return {rli_e, rri_e, up & dbl & (l == LINK_ROT) & b_f15,
            dn ? b_f0 : (up ? b_f15 : 1'b0), ci_e};
  endfunction

  task automatic compare(input logic [31:0] got, input logic [31:0] exp, input string what);
    check_count++;
    if (got !== exp) begin
      error_count++;
      $display("mismatch at %0t ns: %s, got %h expected %h", $time, what, got, exp);
    end
  endtask

  task automatic drive_word(input logic [14:0] w, input logic [6:0] dp);
    {csalui_src, csalui_func, csalui_dest, csmis, cscinsel, csst} <= w;
    {f0, f15, q0, q15, cry, sts6, gpr0} <= dp;
  endtask

  // one microword in, results checked after the edge that samples it.
  task automatic apply_and_check(input logic [14:0] w, input logic [6:0] dp, input string what);
    @(posedge aluclk);
    drive_word(w, dp);
    @(posedge aluclk);
    @(negedge aluclk);
    compare(32'(dec_got), 32'(decode_model(w)), {what, " decode"});
    compare(32'(link_got), 32'(link_model(w, dp)), {what, " link"});
  endtask

  task automatic finish_test(input string name, input int chk0, input int err0);
    test_count++;
    $display("%s finished, %0d checks, %0d errors", name, check_count - chk0,
             error_count - err0);
  endtask

  task automatic reset_values();
    int chk0;
    int err0;
    chk0 = check_count;
    err0 = error_count;
    @(negedge aluclk);
    compare(32'(dec_got), 32'({4'b1000, 4'b0000, 4'b0110, 2'b00, 2'b00}), "reset decode");
    compare(32'(link_got), 32'h0, "reset link");
    finish_test("reset_values", chk0, err0);
  endtask

  // field 0 is source, 1 function, 2 destination.
  task automatic field_sweep(input int field, input string name);
    int          chk0;
    int          err0;
    logic [31:0] r;
    logic [14:0] w;
    chk0 = check_count;
    err0 = error_count;
    for (int k = 0; k < 8; k++) begin
      r = rand_bits(22);
      w = r[14:0];
      if (field == 0) w[14:12] = 3'(k);
      else if (field == 1) w[11:9] = 3'(k);
      else w[8:6] = 3'(k);
      apply_and_check(w, r[21:15], $sformatf("%s code %0d", name, k));
    end
    finish_test(name, chk0, err0);
  endtask

  task automatic shift_links();
    int          chk0;
    int          err0;
    logic [31:0] r;
    logic [14:0] w;
    chk0 = check_count;
    err0 = error_count;
    for (int k = 0; k < 16; k++) begin
      r = rand_bits(22);
      w = r[14:0];
      w[8:6] = k[3] ? (k[2] ? DST_RAMQU : DST_RAMU) : (k[2] ? DST_RAMQD : DST_RAMD);
      w[5:4] = k[1:0];
      apply_and_check(w, r[21:15], $sformatf("shift case %0d", k));
    end
    finish_test("shift_links", chk0, err0);
  endtask

  task automatic carry_select();
    int          chk0;
    int          err0;
    logic [31:0] r;
    logic [14:0] w;
    chk0 = check_count;
    err0 = error_count;
    for (int k = 0; k < 16; k++) begin
      r = rand_bits(22);
      w = r[14:0];
      w[3:2] = k[1:0];
      apply_and_check(w, r[21:15], $sformatf("carry select %0d pass %0d", k[1:0], k[3:2]));
    end
    finish_test("carry_select", chk0, err0);
  endtask

  // a new word every edge, each checked against the word one edge older.
  task automatic back_to_back();
    int          chk0;
    int          err0;
    logic [31:0] r;
    logic [14:0] word;
    logic [14:0] prev_word;
    logic [6:0]  dp;
    chk0 = check_count;
    err0 = error_count;
    word = '0;
    dp   = '0;
    for (int i = 0; i <= stream_words; i++) begin
      prev_word = word;
      @(posedge aluclk);
      if (i < stream_words) begin
        r    = rand_bits(22);
        word = r[14:0];
        dp   = r[21:15];
        drive_word(word, dp);
      end
      @(negedge aluclk);
      if (i > 0) begin
        compare(32'(dec_got), 32'(decode_model(prev_word)), $sformatf("stream word %0d", i - 1));
        compare(32'(link_got), 32'(link_model(prev_word, dp)), $sformatf("stream link %0d", i - 1));
      end
    end
    finish_test("back_to_back", chk0, err0);
  endtask

  initial begin
    rst = 1'b1;
    // all ones on the pins, far from the reset microword.
    {csalui_src, csalui_func, csalui_dest, csmis, cscinsel, csst} = '1;
    {f0, f15, q0, q15, cry, sts6, gpr0} = '1;
    repeat (3) @(posedge aluclk);
    rst <= 1'b0;
    reset_values();
    field_sweep(0, "source_decode");
    field_sweep(1, "function_decode");
    field_sweep(2, "dest_decode");
    shift_links();
    carry_select();
    back_to_back();
    $display("tests %0d, checks %0d, errors %0d", test_count, check_count, error_count);
    if (error_count == 0) begin
      $display("Simulation passed");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== filelist.f ====
+incdir+hw
hw/alu_contr_pkg.sv
hw/alu_shift_if.sv
hw/alu_field_decode.sv
hw/alu_link_ctl.sv
hw/alu_contr.sv
testbench/tb_alu_contr.sv

// ==== Makefile ====
# Verilator build and run of the ALU controller testbench.
TOP     := tb_alu_contr
SIM_LOG := sim.log

.PHONY: all compile run clean

all: run

compile: obj_dir/V$(TOP)

obj_dir/V$(TOP): filelist.f hw/*.sv hw/*.svh testbench/*.sv
	verilator --binary --timing --assert -j 0 --top-module $(TOP) -f filelist.f

# the log decides the result, a missing pass line fails the target.
run: compile
	./obj_dir/V$(TOP) > $(SIM_LOG) 2>&1; cat $(SIM_LOG)
	grep -q "^Simulation passed$$" $(SIM_LOG)

clean:
	rm -rf obj_dir $(SIM_LOG)
